/* all.f */
src/route_pkg.sv
src/addr_decode.sv
src/write_guard.sv
src/route_stage.sv
src/addr_route_top.sv
bench/addr_route_asserts.sv
bench/addr_route_tb.sv

/* Bender.yml */
package:
  name: addr_route

sources:
  - src/route_pkg.sv
  - src/addr_decode.sv
  - src/write_guard.sv
  - src/route_stage.sv
  - src/addr_route_top.sv
  - target: test
    files:
      - bench/addr_route_asserts.sv
      - bench/addr_route_tb.sv

/* bench/route_tests.txt */
# rule <n> <start> <end> <idx> | guard <n> <start> <end> | default <en> <idx> | burst <count>
# req <addr> <write> <expected idx> <expected err> | end closes the file, numbers in hex
rule 0 00000000 00001000 1
rule 1 00001000 00002000 2
rule 2 00002000 00004000 3
rule 3 00003000 00003800 4
rule 4 00010000 00020000 5
rule 5 00018000 00019000 6
rule 6 00040000 00050000 7
rule 7 00044000 00046000 8
guard 0 00001800 00001c00
guard 1 00018000 00018400
guard 2 00030000 00031000
guard 3 00048000 00049000
req 00000010 0 1 0
req 00003100 0 4 0
req 00003800 0 3 0
req 00004000 0 0 1
req 00018010 0 6 0
req 00045000 0 8 0
req 00001800 1 0 2
req 00001800 0 2 0
req 00030010 1 0 1
req 00001c00 1 2 0
default 1 9
req 00004000 0 9 0
req 00030010 1 0 2
burst 4
req 00001004 0 2 0
req 00019000 0 5 0
req 00048100 1 0 2
req 00050000 0 9 0
end

/* bench/addr_route_tb.sv */
`timescale 1ns/10ps

module addr_route_tb;

  import route_pkg::*;

  localparam int unsigned NoRules   = 8;
  localparam int unsigned NoGuards  = 4;
  localparam int unsigned NoIndices = 16;

  // Operation kinds in the data file
  localparam int OpReq     = 0;
  localparam int OpDefault = 1;
  localparam int OpBurst   = 2;

  logic                 clk_i = 1'b0;
  logic                 reset_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  addr_t                in_addr_i;
  logic                 in_write_i;
  addr_t [NoRules-1:0]  rule_start_i;
  addr_t [NoRules-1:0]  rule_end_i;
  idx_t  [NoRules-1:0]  rule_idx_i;
  logic                 en_default_i;
  idx_t                 default_idx_i;
  addr_t [NoGuards-1:0] guard_start_i;
  addr_t [NoGuards-1:0] guard_end_i;
  logic                 out_valid_o;
  logic                 out_ready_i;
  idx_t                 out_idx_o;
  err_t                 out_err_o;

  // Operations from the data file, in order
  int          op_kind[$];
  logic [31:0] op_a[$];
  logic [31:0] op_b[$];
  logic [31:0] op_c[$];
  logic [31:0] op_d[$];

  // Decisions still owed by the DUT
  idx_t exp_idx_q[$];
  err_t exp_err_q[$];

  int          req_total = 0;
  int          accept_count = 0;
  int          out_count = 0;
  int          cycle_cnt = 0;
  int          accept_cycle = 0;
  int          last_out_cycle = 0;
  int          burst_left = 0;
  int          burst_len = 0;
  int          burst_start = 0;
  logic        fast_ready = 1'b0;
  logic        loaded = 1'b0;
  logic [31:0] lcg_state = 32'd27;

  // Output register holds a decision in the reference model
  logic        held = 1'b0;

  addr_route_top #(
    .NoRules   (NoRules),
    .NoGuards  (NoGuards),
    .NoIndices (NoIndices)
  ) uut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_addr_i     (in_addr_i),
    .in_write_i    (in_write_i),
    .rule_start_i  (rule_start_i),
    .rule_end_i    (rule_end_i),
    .rule_idx_i    (rule_idx_i),
    .en_default_i  (en_default_i),
    .default_idx_i (default_idx_i),
    .guard_start_i (guard_start_i),
    .guard_end_i   (guard_end_i),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_idx_o     (out_idx_o),
    .out_err_o     (out_err_o)
  );

  bind route_stage addr_route_asserts u_route_asserts (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_idx_o   (out_idx_o),
    .out_err_o   (out_err_o)
  );

  // 40 ns clock period
  always #20 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0d ns: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // LCG, upper bits are the better ones
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
  endfunction

  // About 70 percent ready unless a burst holds it high
  task automatic update_ready();
    out_ready_i = fast_ready ? 1'b1 : ((next_random() % 100) < 70);
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #2;
    update_ready();
  endtask

  task automatic wait_drain();
    while (out_count != accept_count) begin
      idle_cycle();
    end
  endtask

  task automatic push_op(input int kind, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] c, input logic [31:0] d);
    op_kind.push_back(kind);
    op_a.push_back(a);
    op_b.push_back(b);
    op_c.push_back(c);
    op_d.push_back(d);
  endtask

  // Hold the request until the DUT takes it
  task automatic send_request(input addr_t addr, input logic wr, input idx_t e_idx,
                              input err_t e_err);
    logic accepted;
    accepted = 1'b0;
    in_valid_i = 1'b1;
    in_addr_i = addr;
    in_write_i = wr;
    while (!accepted) begin
      @(posedge clk_i);
      if (in_ready_o) begin
        accepted = 1'b1;
        exp_idx_q.push_back(e_idx);
        exp_err_q.push_back(e_err);
        accept_count++;
        accept_cycle = cycle_cnt;
      end
      #2;
      update_ready();
    end
    in_valid_i = 1'b0;
  endtask

  // Tables go straight to the DUT inputs, the rest is queued
  task automatic read_tests();
    int            fd;
    int            n;
    int            i;
    logic [63:0]   tok;
    logic [1023:0] skip;
    logic [31:0]   a;
    logic [31:0]   b;
    logic [31:0]   c;
    logic [31:0]   d;
    logic          done;
    fd = $fopen("bench/route_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the test data file bench/route_tests.txt");
    end
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        abort_run("Test data file ends without an end line");
      end else if (tok == "#") begin
        n = $fgets(skip, fd);
      end else if (tok == "rule") begin
        n = $fscanf(fd, "%d %h %h %h", i, a, b, c);
        if (i < 0 || i >= NoRules || c >= NoIndices) begin
          abort_run("Rule line with a bad rule number or index in test data");
        end else begin
          rule_start_i[i] = a;
          rule_end_i[i] = b;
          rule_idx_i[i] = c[IdxWidth-1:0];
        end
      end else if (tok == "guard") begin
        n = $fscanf(fd, "%d %h %h", i, a, b);
        if (i < 0 || i >= NoGuards) begin
          abort_run("Guard line with a bad region number in test data");
        end else begin
          guard_start_i[i] = a;
          guard_end_i[i] = b;
        end
      end else if (tok == "default") begin
        n = $fscanf(fd, "%h %h", a, b);
        push_op(OpDefault, a, b, 0, 0);
      end else if (tok == "burst") begin
        n = $fscanf(fd, "%d", a);
        push_op(OpBurst, a, 0, 0, 0);
      end else if (tok == "req") begin
        n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
        if (c >= NoIndices) begin
          abort_run("Request line expects an index beyond the valid targets");
        end else begin
          push_op(OpReq, a, b, c, d);
          req_total++;
        end
      end else if (tok == "end") begin
        done = 1'b1;
      end else begin
        abort_run($sformatf("Unknown keyword %0s in test data", tok));
      end
    end
    $fclose(fd);
  endtask

  // Output side, every transfer is checked against the oldest request
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (reset_i) begin
      held <= 1'b0;
    end else begin
      // Handshake follows the occupancy of the single output register
      check_value("out_valid_o", out_valid_o, held);
      check_value("in_ready_o", in_ready_o, !held || out_ready_i);
      held <= (in_valid_i && in_ready_o) || (held && !out_ready_i);
      if (out_valid_o && out_ready_i) begin
        if (exp_idx_q.size() == 0) begin
          abort_run("Output transfer seen with no request waiting for it");
        end else begin
          check_value("out_idx_o", out_idx_o, exp_idx_q.pop_front());
          check_value("out_err_o", out_err_o, exp_err_q.pop_front());
          out_count++;
          last_out_cycle = cycle_cnt;
        end
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (req_total * 10 + 50) @(posedge clk_i);
    abort_run($sformatf("Timeout, run did not finish in %0d cycles", req_total * 10 + 50));
  end

  initial begin
    reset_i = 1'b1;
    in_valid_i = 1'b0;
    in_addr_i = '0;
    in_write_i = 1'b0;
    rule_start_i = '0;
    rule_end_i = '0;
    rule_idx_i = '0;
    en_default_i = 1'b0;
    default_idx_i = '0;
    guard_start_i = '0;
    guard_end_i = '0;
    out_ready_i = 1'b0;
    read_tests();
    loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    update_ready();
    for (int k = 0; k < op_kind.size(); k++) begin
      case (op_kind[k])
        OpDefault: begin
          // Earlier requests already hold their decision
          en_default_i = op_a[k][0];
          default_idx_i = op_b[k][IdxWidth-1:0];
        end
        OpBurst: begin
          wait_drain();
          fast_ready = 1'b1;
          idle_cycle();
          burst_left = op_a[k];
          burst_len = op_a[k];
        end
        default: begin
          send_request(op_a[k], op_b[k][0], op_c[k][IdxWidth-1:0], op_d[k][ErrWidth-1:0]);
          if (burst_left > 0) begin
            if (burst_left == burst_len) begin
              burst_start = accept_cycle;
            end
            burst_left--;
            if (burst_left == 0) begin
              wait_drain();
              // One transfer per cycle, N outputs by N+1 cycles after the first accept
              if (last_out_cycle - burst_start > burst_len + 1) begin
                abort_run($sformatf("Burst of %0d requests took %0d cycles",
                                    burst_len, last_out_cycle - burst_start));
              end else begin
                fast_ready = 1'b0;
              end
            end
          end
        end
      endcase
    end
    wait_drain();
    // Extra transfers would trip the monitor here
    repeat (3) idle_cycle();
    if (uut.u_route_stage.u_route_asserts.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      abort_run("Concurrent assertions in route_stage failed during the run");
    end
  end

endmodule

/* bench/addr_route_asserts.sv */
`timescale 1ns/10ps

module addr_route_asserts (
  input logic            clk_i,
  input logic            reset_i,
  input logic            out_valid_o,
  input logic            out_ready_i,
  input route_pkg::idx_t out_idx_o,
  input route_pkg::err_t out_err_o
);

  import route_pkg::*;

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // Output register comes up empty
  assert property (@(posedge clk_i) reset_i |=> !out_valid_o)
    else begin
      $error("out_valid_o high right after reset");
      fail_count++;
    end

  // Stalled decision holds until taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(out_idx_o) && $stable(out_err_o)))
    else begin
      $error("Output changed while stalled");
      fail_count++;
    end

  // Any error forces index zero
  assert property (@(posedge clk_i) disable iff (reset_i)
    (out_valid_o && out_err_o != ErrNone) |-> (out_idx_o == '0))
    else begin
      $error("Nonzero index on an error decision");
      fail_count++;
    end

endmodule

/* src/addr_route_top.sv */
`timescale 1ns/10ps

module addr_route_top #(
  // Rule table depth
  parameter int unsigned NoRules   = 8,
  // Protected region count
  parameter int unsigned NoGuards  = 4,
  // Valid targets, at most 16 with a 4 bit index
  parameter int unsigned NoIndices = 16
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // Request input
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  input  route_pkg::addr_t                in_addr_i,
  input  logic                            in_write_i,
  // Rule table
  input  route_pkg::addr_t [NoRules-1:0]  rule_start_i,
  input  route_pkg::addr_t [NoRules-1:0]  rule_end_i,
  input  route_pkg::idx_t  [NoRules-1:0]  rule_idx_i,
  // Default mapping
  input  logic                            en_default_i,
  input  route_pkg::idx_t                 default_idx_i,
  // Guard table
  input  route_pkg::addr_t [NoGuards-1:0] guard_start_i,
  input  route_pkg::addr_t [NoGuards-1:0] guard_end_i,
  // Decision output
  output logic                            out_valid_o,
  input  logic                            out_ready_i,
  output route_pkg::idx_t                 out_idx_o,
  output route_pkg::err_t                 out_err_o
);

  import route_pkg::*;

  // Checker results toward the output stage
  logic dec_match;
  idx_t dec_idx;
  logic wr_denied;

  // Both checkers see the request in parallel
  addr_decode #(
    .NoRules (NoRules)
  ) u_addr_decode (
    .addr_i        (in_addr_i),
    .rule_start_i  (rule_start_i),
    .rule_end_i    (rule_end_i),
    .rule_idx_i    (rule_idx_i),
    .en_default_i  (en_default_i),
    .default_idx_i (default_idx_i),
    .match_o       (dec_match),
    .idx_o         (dec_idx)
  );

  write_guard #(
    .NoGuards (NoGuards)
  ) u_write_guard (
    .addr_i        (in_addr_i),
    .write_i       (in_write_i),
    .guard_start_i (guard_start_i),
    .guard_end_i   (guard_end_i),
    .denied_o      (wr_denied)
  );

  // Single register stage, one cycle of latency
  route_stage #(
    .NoIndices (NoIndices)
  ) u_route_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .match_i     (dec_match),
    .idx_i       (dec_idx),
    .denied_i    (wr_denied),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_idx_o   (out_idx_o),
    .out_err_o   (out_err_o)
  );

endmodule

/* src/route_stage.sv */
`timescale 1ns/10ps

module route_stage #(
  // Number of valid targets, bounds the index range seen by checkers
  parameter int unsigned NoIndices = 16
) (
  input  logic            clk_i,
  input  logic            reset_i,
  // Upstream handshake
  input  logic            in_valid_i,
  output logic            in_ready_o,
  // Decoder result
  input  logic            match_i,
  input  route_pkg::idx_t idx_i,
  // Guard result
  input  logic            denied_i,
  // Downstream handshake and decision
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output route_pkg::idx_t out_idx_o,
  output route_pkg::err_t out_err_o
);

  import route_pkg::*;

  // Decision for the request on the input side
  err_t dec_err;
  idx_t dec_idx;

  // Output register
  logic valid_q;
  idx_t idx_q;
  err_t err_q;

  // Request moves into the register this cycle
  logic load;

  // Error code, decode error ahead of a denied write
  always_comb begin
    if (!match_i) begin
      dec_err = ErrDecode;
    end else if (denied_i) begin
      dec_err = ErrDenied;
    end else begin
      dec_err = ErrNone;
    end
  end

  // Index is zero on any error
  assign dec_idx = (dec_err == ErrNone) ? idx_i : '0;

  // Room when empty or when the held decision leaves now
  assign in_ready_o = ~valid_q | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  // Valid flag, refilled or drained whenever the register is free
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload only changes on an accepted request
  always_ff @(posedge clk_i) begin
    if (load) begin
      idx_q <= dec_idx;
      err_q <= dec_err;
    end
  end

  assign out_valid_o = valid_q;
  assign out_idx_o   = idx_q;
  assign out_err_o   = err_q;

endmodule

/* src/write_guard.sv */
`timescale 1ns/10ps

module write_guard #(
  // Number of protected regions
  parameter int unsigned NoGuards = 4
) (
  // Request address
  input  route_pkg::addr_t                 addr_i,
  // Request is a write
  input  logic                             write_i,
  // Region table, start bound included
  input  route_pkg::addr_t [NoGuards-1:0]  guard_start_i,
  // Region table, end bound excluded
  input  route_pkg::addr_t [NoGuards-1:0]  guard_end_i,
  // Write lands in a protected region
  output logic                             denied_o
);

  // One bit per region covering the address
  logic [NoGuards-1:0] region_hit;

  // Address lies somewhere in the protected space
  logic                protected_addr;

  // Range compare per region
  for (genvar g = 0; g < NoGuards; g++) begin : gen_guard_cmp
    // Same bound convention as the rule table
    assign region_hit[g] = (addr_i >= guard_start_i[g]) && (addr_i < guard_end_i[g]);
  end

  // Overlapping regions are fine, any hit is enough
  assign protected_addr = |region_hit;

  // Reads always pass
  assign denied_o = write_i & protected_addr;

endmodule

/* src/addr_decode.sv */
`timescale 1ns/10ps

module addr_decode #(
  // Number of entries in the rule table
  parameter int unsigned NoRules = 8
) (
  // Address to decode
  input  route_pkg::addr_t                addr_i,
  // Rule table, start bound included
  input  route_pkg::addr_t [NoRules-1:0]  rule_start_i,
  // Rule table, end bound excluded
  input  route_pkg::addr_t [NoRules-1:0]  rule_end_i,
  // Target index of each rule
  input  route_pkg::idx_t  [NoRules-1:0]  rule_idx_i,
  // Default mapping for unmatched addresses
  input  logic                            en_default_i,
  input  route_pkg::idx_t                 default_idx_i,
  // Decode result
  output logic                            match_o,
  output route_pkg::idx_t                 idx_o
);

  import route_pkg::*;

  // One bit per rule whose range covers the address
  logic [NoRules-1:0] rule_hit;

  // Index picked from the table, before the default applies
  idx_t               table_idx;

  // Any rule at all covers the address
  logic               any_hit;

  // Range compare per rule
  for (genvar r = 0; r < NoRules; r++) begin : gen_rule_cmp
    // Start inclusive, end exclusive
    assign rule_hit[r] = (addr_i >= rule_start_i[r]) && (addr_i < rule_end_i[r]);
  end

  // Priority select over the hit vector
  always_comb begin
    table_idx = '0;
    // Later rules overwrite earlier ones, so the highest match wins
    for (int unsigned r = 0; r < NoRules; r++) begin
      if (rule_hit[r]) begin
        table_idx = rule_idx_i[r];
      end
    end
  end

  assign any_hit = |rule_hit;

  // Default counts as a match when enabled
  assign match_o = any_hit | en_default_i;

  // Table index first, then default, otherwise zero
  always_comb begin
    if (any_hit) begin
      idx_o = table_idx;
    end else if (en_default_i) begin
      idx_o = default_idx_i;
    end else begin
      idx_o = '0;
    end
  end

endmodule

/* src/route_pkg.sv */
package route_pkg;

  // Field widths of a routed request
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned IdxWidth  = 4;
  localparam int unsigned ErrWidth  = 2;

  // Request address, also used for rule and region bounds
  typedef logic [AddrWidth-1:0] addr_t;

  // Target index, up to 16 targets
  typedef logic [IdxWidth-1:0] idx_t;

  // Routing error code
  typedef logic [ErrWidth-1:0] err_t;

  // Request routed to a target
  localparam err_t ErrNone   = 2'd0;

  // No rule matched and no default index enabled
  localparam err_t ErrDecode = 2'd1;

  // Write into a protected region
  localparam err_t ErrDenied = 2'd2;

  // Decode error is reported ahead of a denied write
  // Code 3 is reserved

endpackage
